// ==== design/mc_blk_counter.sv ====
// Step counter over the 4x4 halves of each prediction block; builds transform enables and numbers
`timescale 1ns/1ps

module mc_blk_counter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         pred_valid_i,
  input  logic [mc_pkg::BLK_IDX_W-1:0] pred_blk_i,
  mc_blk_step_if.ctl                   step_if,
  output logic                         tq_luma_en_o,
  output logic [3:0]                   tq_luma_num_o,
  output logic                         tq_chroma_en_o,
  output logic [2:0]                   tq_chroma_num_o
);
  import mc_pkg::*;

  localparam int LUMA_STEP_NUM = LUMA_BLK_NUM * 2;

  logic [STEP_W-1:0] out_cnt_r;
  logic              luma_en_r;
  logic              chroma_en_r;
  logic              is_luma;

  // ------------------------------
  // Step count and enable
  // ------------------------------
  // New block restarts at its first half
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_if.step <= '0;
    end else if (pred_valid_i) begin
      step_if.step <= {pred_blk_i, 1'b0};
    end else if (step_if.step == STEP_W'(STEP_NUM - 1)) begin
      step_if.step <= '0;
    end else if (step_if.step_en) begin
      step_if.step <= step_if.step + 1'b1;
    end
  end

  // Enable lasts for both halves, drops after the odd one
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      step_if.step_en <= 1'b0;
    else if (pred_valid_i)
      step_if.step_en <= 1'b1;
    else if (step_if.step[0])
      step_if.step_en <= 1'b0;
  end

  // ------------------------------
  // Output stage, one cycle later
  // ------------------------------
  assign is_luma = (step_if.step < STEP_W'(LUMA_STEP_NUM));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt_r   <= '0;
      luma_en_r   <= 1'b0;
      chroma_en_r <= 1'b0;
    end else begin
      out_cnt_r   <= step_if.step;
      luma_en_r   <= step_if.step_en & is_luma;
      chroma_en_r <= step_if.step_en & ~is_luma;
    end
  end

  assign step_if.out_half = out_cnt_r[0];
  assign tq_luma_en_o     = luma_en_r;
  assign tq_chroma_en_o   = chroma_en_r;
  // Numbers wrap inside each plane
  assign tq_luma_num_o    = out_cnt_r[3:0];
  assign tq_chroma_num_o  = out_cnt_r[2:0];

endmodule

// ==== design/mc_blk_step_if.sv ====
// Block-step control from the step counter to the current-select and prediction-buffer modules
`timescale 1ns/1ps

interface mc_blk_step_if;
  import mc_pkg::*;

  // Upper bits pick the 8x4 block, bit 0 the 4x4 half
  logic [STEP_W-1:0] step;
  logic              step_en;
  // Half of the step that is on the outputs this cycle
  logic              out_half;

  modport ctl (
    output step,
    output step_en,
    output out_half
  );

  modport src (
    input step
  );

  modport rec (
    input out_half
  );

endinterface

// ==== design/mc_cur_select.sv ====
// Picks the current-macroblock 8x4 block for the active step and returns its requested 4x4 half
`timescale 1ns/1ps

module mc_cur_select #(
  parameter int PIX_W = 8
) (
  input  logic [256*PIX_W-1:0]                    cur_luma_i,
  input  logic [64*PIX_W-1:0]                     cur_cb_i,
  input  logic [64*PIX_W-1:0]                     cur_cr_i,
  mc_blk_step_if.src                              step_if,
  output logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0] cur_half_o
);
  import mc_pkg::*;

  localparam int CHROMA_BLK_NUM = (BLK_NUM - LUMA_BLK_NUM) / 2;
  localparam int BLK_W          = PIX_PER_BLK8X4 * PIX_W;
  // One 8-pixel row of an 8x4 block
  localparam int ROW_W          = 8 * PIX_W;

  logic [BLK_W-1:0] blk8x4 [BLK_NUM];
  logic [BLK_W-1:0] blk_sel;
  logic             half;

  // ------------------------------
  // 8x4 blocks of the macroblock
  // ------------------------------
  // Luma blocks walk the 8x8 quadrants in raster order, top then bottom 8x4
  always_comb begin
    for (int x = 0; x < LUMA_BLK_NUM; x++) begin
      for (int i = 0; i < 4; i++) begin
        blk8x4[x][i*ROW_W +: ROW_W] =
          cur_luma_i[(((x/4)*8 + (x%2)*4 + i)*16 + ((x/2)%2)*8)*PIX_W +: ROW_W];
      end
    end
    // Chroma blocks are plain 4-row stripes
    for (int y = 0; y < CHROMA_BLK_NUM; y++) begin
      blk8x4[LUMA_BLK_NUM+y]                = cur_cb_i[y*BLK_W +: BLK_W];
      blk8x4[LUMA_BLK_NUM+CHROMA_BLK_NUM+y] = cur_cr_i[y*BLK_W +: BLK_W];
    end
  end

  assign blk_sel = blk8x4[step_if.step[STEP_W-1:1]];
  assign half    = step_if.step[0];

  // ------------------------------
  // 4x4 half, row-major
  // ------------------------------
  // Half 1 starts at column 4
  always_comb begin
    for (int k = 0; k < PIX_PER_BLK4X4; k++) begin
      cur_half_o[k*PIX_W +: PIX_W] =
        blk_sel[((k/4)*8 + (half ? 4 : 0) + (k%4))*PIX_W +: PIX_W];
    end
  end

endmodule

// ==== design/mc_pkg.sv ====
// Shared block counts, counter widths and type-word field offsets for the MC residual front end
package mc_pkg;

  // ------------------------------
  // Block and step counts
  // ------------------------------
  // 8x4 prediction blocks per macroblock
  localparam int BLK_NUM        = 12;
  // Luma blocks come first, steps below 2*LUMA_BLK_NUM are luma
  localparam int LUMA_BLK_NUM   = 8;
  // Two 4x4 steps per 8x4 block
  localparam int STEP_NUM       = 24;
  localparam int STEP_W         = 5;
  localparam int BLK_IDX_W      = 4;

  localparam int PIX_PER_BLK8X4 = 32;
  localparam int PIX_PER_BLK4X4 = 16;

  // ------------------------------
  // Macroblock type word
  // ------------------------------
  localparam int MB_TYPE_W      = 15;
  localparam int MB_TYPE_LSB    = 0;
  // Sub-macroblock type fields, 3 bits each
  localparam int SUB_TYPE_LSB0  = 3;
  localparam int SUB_TYPE_LSB1  = 6;
  localparam int SUB_TYPE_LSB2  = 9;
  localparam int SUB_TYPE_LSB3  = 12;

  // Cr 4x4 block number that closes a macroblock
  localparam int CR_LAST_NUM    = 3;

endpackage

// ==== design/mc_pred_buf.sv ====
// Holds the latest prediction block; gives out 4x4 halves for subtraction and for reconstruction
`timescale 1ns/1ps

module mc_pred_buf #(
  parameter int PIX_W = 8
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    pred_valid_i,
  input  logic [mc_pkg::PIX_PER_BLK8X4*PIX_W-1:0] pred_data_i,
  mc_blk_step_if.src                              step_src_if,
  mc_blk_step_if.rec                              step_rec_if,
  output logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0] pred_half_o,
  output logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0] pred_rec_o
);
  import mc_pkg::*;

  localparam int BLK_W  = PIX_PER_BLK8X4 * PIX_W;
  localparam int HALF_W = PIX_PER_BLK4X4 * PIX_W;

  logic [BLK_W-1:0] pred_r;

  // Left or right 4x4 of an 8x4 block
  function automatic logic [HALF_W-1:0] pick_half(input logic [BLK_W-1:0] blk,
                                                  input logic             half);
    logic [HALF_W-1:0] h;
    for (int k = 0; k < PIX_PER_BLK4X4; k++)
      h[k*PIX_W +: PIX_W] = blk[((k/4)*8 + (half ? 4 : 0) + (k%4))*PIX_W +: PIX_W];
    return h;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      pred_r <= '0;
    else if (pred_valid_i)
      pred_r <= pred_data_i;
  end

  // Subtraction runs on the live step, reconstruction one cycle behind
  assign pred_half_o = pick_half(pred_r, step_src_if.step[0]);
  assign pred_rec_o  = pick_half(pred_r, step_rec_if.out_half);

endmodule

// ==== design/mc_residual.sv ====
// Registered per-pixel residual, current minus prediction, one bit wider than a pixel
`timescale 1ns/1ps

module mc_residual #(
  parameter int PIX_W = 8
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0]     cur_half_i,
  input  logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0]     pred_half_i,
  output logic [mc_pkg::PIX_PER_BLK4X4*(PIX_W+1)-1:0] res_pix_o
);
  import mc_pkg::*;

  localparam int RES_W = PIX_W + 1;

  logic [PIX_PER_BLK4X4*RES_W-1:0] res;

  // Zero-extend both pixels so the difference is signed
  always_comb begin
    for (int k = 0; k < PIX_PER_BLK4X4; k++) begin
      res[k*RES_W +: RES_W] = $signed({1'b0, cur_half_i[k*PIX_W +: PIX_W]}) -
                              $signed({1'b0, pred_half_i[k*PIX_W +: PIX_W]});
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      res_pix_o <= '0;
    else
      res_pix_o <= res;
  end

endmodule

// ==== design/mc_seq_fsm.sv ====
// Idle/run control of one macroblock; latches the type word, drives entropy-coder fields and done
`timescale 1ns/1ps

module mc_seq_fsm (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         start_i,
  input  logic                         tq_cr_val_i,
  input  logic [3:0]                   tq_cr_num_i,
  input  logic [mc_pkg::MB_TYPE_W-1:0] mb_type_info_i,
  output logic                         done_o,
  output logic [1:0]                   ec_mb_type_o,
  output logic [7:0]                   ec_sub_partition_o
);
  import mc_pkg::*;

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_RUN  = 1'b1;

  logic                 state_r;
  logic                 state_nxt;
  logic                 last_ret;
  logic                 done_r;
  logic [MB_TYPE_W-1:0] mb_type_r;

  // Last Cr block back from the transform stage
  assign last_ret = (state_r == ST_RUN) && tq_cr_val_i &&
                    (tq_cr_num_i == 4'(CR_LAST_NUM));

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: if (start_i) state_nxt = ST_RUN;
      ST_RUN:  if (last_ret) state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r   <= ST_IDLE;
      done_r    <= 1'b0;
      mb_type_r <= '0;
    end else begin
      state_r <= state_nxt;
      done_r  <= last_ret;
      if (start_i)
        mb_type_r <= mb_type_info_i;
    end
  end

  assign done_o       = done_r;
  assign ec_mb_type_o = mb_type_r[MB_TYPE_LSB +: 2];
  // Sub type 3 in the top bits
  assign ec_sub_partition_o = {mb_type_r[SUB_TYPE_LSB3 +: 2],
                               mb_type_r[SUB_TYPE_LSB2 +: 2],
                               mb_type_r[SUB_TYPE_LSB1 +: 2],
                               mb_type_r[SUB_TYPE_LSB0 +: 2]};

endmodule

// ==== design/mc_top.sv ====
// Top of the MC residual front end; wires the step counter, block selection and subtraction
`timescale 1ns/1ps

module mc_top #(
  parameter int PIX_W = 8
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Macroblock control
  input  logic                                        start_i,
  input  logic [mc_pkg::MB_TYPE_W-1:0]                mb_type_info_i,
  output logic                                        done_o,
  // Current macroblock
  input  logic [256*PIX_W-1:0]                        cur_luma_i,
  input  logic [64*PIX_W-1:0]                         cur_cb_i,
  input  logic [64*PIX_W-1:0]                         cur_cr_i,
  // Prediction blocks, one pulse per 8x4 block
  input  logic                                        pred_valid_i,
  input  logic [mc_pkg::BLK_IDX_W-1:0]                pred_blk_i,
  input  logic [mc_pkg::PIX_PER_BLK8X4*PIX_W-1:0]     pred_data_i,
  // Entropy coder
  output logic [1:0]                                  ec_mb_type_o,
  output logic [7:0]                                  ec_sub_partition_o,
  // Transform stage
  output logic                                        tq_luma_en_o,
  output logic [3:0]                                  tq_luma_num_o,
  output logic                                        tq_chroma_en_o,
  output logic [2:0]                                  tq_chroma_num_o,
  input  logic                                        tq_cr_val_i,
  input  logic [3:0]                                  tq_cr_num_i,
  output logic [mc_pkg::PIX_PER_BLK4X4*PIX_W-1:0]     pred_pix_o,
  output logic [mc_pkg::PIX_PER_BLK4X4*(PIX_W+1)-1:0] res_pix_o
);
  import mc_pkg::*;

  logic [PIX_PER_BLK4X4*PIX_W-1:0] cur_half;
  logic [PIX_PER_BLK4X4*PIX_W-1:0] pred_half;

  mc_blk_step_if u_step_if ();

  // ------------------------------
  // Control
  // ------------------------------
  mc_seq_fsm u_seq_fsm (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .start_i            (start_i),
    .tq_cr_val_i        (tq_cr_val_i),
    .tq_cr_num_i        (tq_cr_num_i),
    .mb_type_info_i     (mb_type_info_i),
    .done_o             (done_o),
    .ec_mb_type_o       (ec_mb_type_o),
    .ec_sub_partition_o (ec_sub_partition_o)
  );

  mc_blk_counter u_blk_counter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pred_valid_i    (pred_valid_i),
    .pred_blk_i      (pred_blk_i),
    .step_if         (u_step_if.ctl),
    .tq_luma_en_o    (tq_luma_en_o),
    .tq_luma_num_o   (tq_luma_num_o),
    .tq_chroma_en_o  (tq_chroma_en_o),
    .tq_chroma_num_o (tq_chroma_num_o)
  );

  // ------------------------------
  // Data path
  // ------------------------------
  mc_cur_select #(
    .PIX_W (PIX_W)
  ) u_cur_select (
    .cur_luma_i (cur_luma_i),
    .cur_cb_i   (cur_cb_i),
    .cur_cr_i   (cur_cr_i),
    .step_if    (u_step_if.src),
    .cur_half_o (cur_half)
  );

  // Reconstruction half goes straight out beside the residual
  mc_pred_buf #(
    .PIX_W (PIX_W)
  ) u_pred_buf (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pred_valid_i (pred_valid_i),
    .pred_data_i  (pred_data_i),
    .step_src_if  (u_step_if.src),
    .step_rec_if  (u_step_if.rec),
    .pred_half_o  (pred_half),
    .pred_rec_o   (pred_pix_o)
  );

  mc_residual #(
    .PIX_W (PIX_W)
  ) u_residual (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cur_half_i  (cur_half),
    .pred_half_i (pred_half),
    .res_pix_o   (res_pix_o)
  );

endmodule

// ==== filelist.f ====
design/mc_pkg.sv
design/mc_blk_step_if.sv
design/mc_seq_fsm.sv
design/mc_blk_counter.sv
design/mc_cur_select.sv
design/mc_pred_buf.sv
design/mc_residual.sv
design/mc_top.sv
test/tb_mc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module tb_mc_top -o tb_mc_top \
  && ./obj_dir/tb_mc_top > sim.log 2>&1 \
  || { echo "Build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
  && { echo "Simulation reported failures"; exit 1; } \
  || { echo "Simulation clean"; exit 0; }

// ==== test/tb_mc_top.sv ====
// Directed testbench for mc_top; drives prediction blocks and checks residuals, numbers and done
`timescale 1ns/1ps

module tb_mc_top;
  import mc_pkg::*;

  localparam int PIX_W           = 8;
  localparam int RES_W           = PIX_W + 1;
  localparam int HALF_W          = PIX_PER_BLK4X4 * PIX_W;
  localparam int RES_HW          = PIX_PER_BLK4X4 * RES_W;
  localparam int PRED_W          = PIX_PER_BLK8X4 * PIX_W;
  localparam int CLK_PERIOD      = 100;
  localparam int DRV             = 10;
  localparam int DONE_WAIT       = 4;
  // Watchdog budget per test
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 60;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 10;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     start_i;
  logic [MB_TYPE_W-1:0]     mb_type_info_i;
  logic                     done_o;
  logic [256*PIX_W-1:0]     cur_luma_i;
  logic [64*PIX_W-1:0]      cur_cb_i;
  logic [64*PIX_W-1:0]      cur_cr_i;
  logic                     pred_valid_i;
  logic [BLK_IDX_W-1:0]     pred_blk_i;
  logic [PRED_W-1:0]        pred_data_i;
  logic [1:0]               ec_mb_type_o;
  logic [7:0]               ec_sub_partition_o;
  logic                     tq_luma_en_o;
  logic [3:0]               tq_luma_num_o;
  logic                     tq_chroma_en_o;
  logic [2:0]               tq_chroma_num_o;
  logic                     tq_cr_val_i;
  logic [3:0]               tq_cr_num_i;
  logic [HALF_W-1:0]        pred_pix_o;
  logic [RES_HW-1:0]        res_pix_o;

  logic [15:0] lfsr_q;
  string       cur_test;
  int          check_cnt;
  int          value_err_cnt;
  int          other_err_cnt;
  int          seen_luma [16];
  int          seen_chroma [8];

  mc_top #(
    .PIX_W (PIX_W)
  ) UUT (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .start_i            (start_i),
    .mb_type_info_i     (mb_type_info_i),
    .done_o             (done_o),
    .cur_luma_i         (cur_luma_i),
    .cur_cb_i           (cur_cb_i),
    .cur_cr_i           (cur_cr_i),
    .pred_valid_i       (pred_valid_i),
    .pred_blk_i         (pred_blk_i),
    .pred_data_i        (pred_data_i),
    .ec_mb_type_o       (ec_mb_type_o),
    .ec_sub_partition_o (ec_sub_partition_o),
    .tq_luma_en_o       (tq_luma_en_o),
    .tq_luma_num_o      (tq_luma_num_o),
    .tq_chroma_en_o     (tq_chroma_en_o),
    .tq_chroma_num_o    (tq_chroma_num_o),
    .tq_cr_val_i        (tq_cr_val_i),
    .tq_cr_num_i        (tq_cr_num_i),
    .pred_pix_o         (pred_pix_o),
    .res_pix_o          (res_pix_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------
  // Random source
  // ------------------------------
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic [PIX_W-1:0] rand_pix();
    logic [31:0] v;
    v = rand_bits(PIX_W);
    return v[PIX_W-1:0];
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  // Pixel k of half h of the current 8x4 block idx
  function automatic logic [PIX_W-1:0] ref_cur_pix(input int idx, input int h, input int k);
    int row;
    int col;
    int rr;
    int cc;
    int y;
    row = k / 4;
    col = h * 4 + k % 4;
    if (idx < LUMA_BLK_NUM) begin
      rr = (idx / 4) * 8 + (idx % 2) * 4 + row;
      cc = ((idx / 2) % 2) * 8 + col;
      return cur_luma_i[(rr * 16 + cc) * PIX_W +: PIX_W];
    end
    y = (idx - LUMA_BLK_NUM) % 2;
    if (idx < LUMA_BLK_NUM + 2)
      return cur_cb_i[((4 * y + row) * 8 + col) * PIX_W +: PIX_W];
    return cur_cr_i[((4 * y + row) * 8 + col) * PIX_W +: PIX_W];
  endfunction

  task automatic build_expected(input int idx, input int h, input logic [PRED_W-1:0] data,
                                output logic [HALF_W-1:0] exp_pix,
                                output logic [RES_HW-1:0] exp_res);
    logic [PIX_W-1:0] c;
    logic [PIX_W-1:0] p;
    int               d;
    for (int k = 0; k < PIX_PER_BLK4X4; k++) begin
      c = ref_cur_pix(idx, h, k);
      p = data[((k / 4) * 8 + h * 4 + k % 4) * PIX_W +: PIX_W];
      d = int'(c) - int'(p);
      exp_pix[k * PIX_W +: PIX_W] = p;
      exp_res[k * RES_W +: RES_W] = d[RES_W-1:0];
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_pix_half(input string what, input logic [HALF_W-1:0] exp,
                                input logic [HALF_W-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      value_err_cnt++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_res_half(input string what, input logic [RES_HW-1:0] exp,
                                input logic [RES_HW-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      value_err_cnt++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_blk_num(input string what, input logic [3:0] exp,
                               input logic [3:0] act);
    check_cnt++;
    if (act !== exp) begin
      value_err_cnt++;
      $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_type_field(input string what, input logic [7:0] exp,
                                  input logic [7:0] act);
    check_cnt++;
    if (act !== exp) begin
      value_err_cnt++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      value_err_cnt++;
      $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // Tally whatever block numbers the DUT reports this cycle
  task automatic record_numbers();
    if (tq_luma_en_o === 1'b1)
      seen_luma[tq_luma_num_o]++;
    if (tq_chroma_en_o === 1'b1)
      seen_chroma[tq_chroma_num_o]++;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  // One prediction pulse, then its two output cycles; leaves 3 cycles between pulses
  task automatic send_pred(input int idx);
    logic [PRED_W-1:0] data;
    logic [HALF_W-1:0] exp_pix;
    logic [RES_HW-1:0] exp_res;
    int                s;
    for (int p = 0; p < PIX_PER_BLK8X4; p++)
      data[p * PIX_W +: PIX_W] = rand_pix();
    pred_valid_i = 1'b1;
    pred_blk_i   = BLK_IDX_W'(idx);
    pred_data_i  = data;
    @(posedge clk_i);
    #DRV;
    pred_valid_i = 1'b0;
    // Bus changes after the pulse, the DUT must keep its own copy
    pred_blk_i   = '0;
    pred_data_i  = ~data;
    record_numbers();
    check_flag("luma enable before output", 1'b0, tq_luma_en_o);
    check_flag("chroma enable before output", 1'b0, tq_chroma_en_o);
    for (int h = 0; h < 2; h++) begin
      @(posedge clk_i);
      #DRV;
      record_numbers();
      s = 2 * idx + h;
      build_expected(idx, h, data, exp_pix, exp_res);
      check_flag("luma enable", s < 16, tq_luma_en_o);
      check_flag("chroma enable", s >= 16, tq_chroma_en_o);
      if (s < 16)
        check_blk_num("luma number", 4'(s % 16), tq_luma_num_o);
      else
        check_blk_num("chroma number", 4'(s % 8), {1'b0, tq_chroma_num_o});
      check_pix_half("prediction half", exp_pix, pred_pix_o);
      check_res_half("residual half", exp_res, res_pix_o);
    end
  endtask

  task automatic test_start_fields();
    logic [31:0]          v;
    logic [MB_TYPE_W-1:0] w;
    logic [7:0]           exp_sub;
    cur_test = "start_fields";
    v = rand_bits(MB_TYPE_W);
    w = v[MB_TYPE_W-1:0];
    // Sub type i sits at bit 3 + 3*i, its low 2 bits go to output bits 2*i
    for (int i = 0; i < 4; i++)
      exp_sub[2 * i +: 2] = w[3 + 3 * i +: 2];
    start_i        = 1'b1;
    mb_type_info_i = w;
    @(posedge clk_i);
    #DRV;
    start_i        = 1'b0;
    mb_type_info_i = '0;
    check_type_field("mb type", {6'd0, w[1:0]}, {6'd0, ec_mb_type_o});
    check_type_field("sub partition", exp_sub, ec_sub_partition_o);
  endtask

  task automatic test_all_blocks();
    int order [BLK_NUM];
    int j;
    int t;
    cur_test = "all_blocks";
    for (int i = 0; i < 16; i++)
      seen_luma[i] = 0;
    for (int i = 0; i < 8; i++)
      seen_chroma[i] = 0;
    for (int i = 0; i < BLK_NUM; i++)
      order[i] = i;
    // Fisher-Yates shuffle
    for (int i = BLK_NUM - 1; i > 0; i--) begin
      j = int'(rand_bits(4)) % (i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (int i = 0; i < BLK_NUM; i++)
      send_pred(order[i]);
    for (int i = 0; i < 16; i++)
      check_blk_num($sformatf("times luma %0d seen", i), 4'd1, 4'(seen_luma[i]));
    for (int i = 0; i < 8; i++)
      check_blk_num($sformatf("times chroma %0d seen", i), 4'd1, 4'(seen_chroma[i]));
  endtask

  task automatic cr_return(input logic [3:0] num);
    tq_cr_val_i = 1'b1;
    tq_cr_num_i = num;
    @(posedge clk_i);
    #DRV;
    tq_cr_val_i = 1'b0;
    tq_cr_num_i = '0;
  endtask

  task automatic test_done();
    int wait_cnt;
    cur_test = "done";
    cr_return(4'd2);
    check_flag("done after Cr 2", 1'b0, done_o);
    @(posedge clk_i);
    #DRV;
    check_flag("done after Cr 2", 1'b0, done_o);
    cr_return(4'(CR_LAST_NUM));
    wait_cnt = 1;
    while (done_o !== 1'b1 && wait_cnt < DONE_WAIT) begin
      @(posedge clk_i);
      #DRV;
      wait_cnt++;
    end
    if (done_o !== 1'b1) begin
      other_err_cnt++;
      $display("Error [%s] done never rose after the last Cr return", cur_test);
    end else if (wait_cnt != 1) begin
      other_err_cnt++;
      $display("Error [%s] done rose %0d cycles after the Cr return", cur_test, wait_cnt);
    end
    @(posedge clk_i);
    #DRV;
    check_flag("done pulse width", 1'b0, done_o);
    // FSM is idle now, so a repeat return is ignored
    cr_return(4'(CR_LAST_NUM));
    check_flag("done after repeat return", 1'b0, done_o);
    @(posedge clk_i);
    #DRV;
    check_flag("done after repeat return", 1'b0, done_o);
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    lfsr_q         = 16'd10;
    check_cnt      = 0;
    value_err_cnt  = 0;
    other_err_cnt  = 0;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    start_i        = 1'b0;
    mb_type_info_i = '0;
    pred_valid_i   = 1'b0;
    pred_blk_i     = '0;
    pred_data_i    = '0;
    tq_cr_val_i    = 1'b0;
    tq_cr_num_i    = '0;
    for (int p = 0; p < 256; p++)
      cur_luma_i[p * PIX_W +: PIX_W] = rand_pix();
    for (int p = 0; p < 64; p++)
      cur_cb_i[p * PIX_W +: PIX_W] = rand_pix();
    for (int p = 0; p < 64; p++)
      cur_cr_i[p * PIX_W +: PIX_W] = rand_pix();
    repeat (2) @(posedge clk_i);
    #DRV;
    cur_test = "reset";
    check_flag("done", 1'b0, done_o);
    check_flag("luma enable", 1'b0, tq_luma_en_o);
    check_flag("chroma enable", 1'b0, tq_chroma_en_o);
    check_res_half("residual", '0, res_pix_o);
    check_pix_half("prediction", '0, pred_pix_o);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #DRV;
    test_start_fields();
    cur_test = "single_luma";
    send_pred(5);
    test_all_blocks();
    test_done();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             check_cnt, value_err_cnt, other_err_cnt);
    if (value_err_cnt + other_err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
